//--- verilog/decodePkg.sv
package decodePkg;

	////////////////////////////////////////
	// Opcode field values
	////////////////////////////////////////

	// All R-type share opcode zero
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opLui   = 6'h0f;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opJal   = 6'h03;

	// Funct values under opRType
	localparam logic [5:0] functAddu = 6'h21;
	localparam logic [5:0] functSubu = 6'h23;
	localparam logic [5:0] functSll  = 6'h00;
	localparam logic [5:0] functJr   = 6'h08;

	////////////////////////////////////////
	// Instruction kind codes
	////////////////////////////////////////

	// Nop stays zero to match the all-zero reset bundle
	localparam logic [3:0] kindNop     = 4'd0;
	localparam logic [3:0] kindAddu    = 4'd1;
	localparam logic [3:0] kindSubu    = 4'd2;
	localparam logic [3:0] kindOri     = 4'd3;
	localparam logic [3:0] kindLw      = 4'd4;
	localparam logic [3:0] kindSw      = 4'd5;
	localparam logic [3:0] kindBeq     = 4'd6;
	localparam logic [3:0] kindLui     = 4'd7;
	localparam logic [3:0] kindJ       = 4'd8;
	localparam logic [3:0] kindJal     = 4'd9;
	localparam logic [3:0] kindJr      = 4'd10;
	localparam logic [3:0] kindSll     = 4'd11;
	// Anything outside the supported subset
	localparam logic [3:0] kindIllegal = 4'd15;

	// Return address register for jal
	localparam logic [4:0] linkReg = 5'd31;

	// Jump target when nothing jumps
	localparam logic [31:0] resetVector = 32'h0000_3000;

	////////////////////////////////////////
	// Instruction word views
	////////////////////////////////////////

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iFields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target26;
	} jFields_t;

	// Same 32 bits read by format
	typedef union packed {
		rFields_t r;
		iFields_t i;
		jFields_t j;
	} instrWord_t;

	// Decoder output
	typedef struct packed {
		logic [3:0] kind;
		logic       zeroExtend;
		logic       writesRt;
		logic       link;
	} decodeCtrl_t;

	// Writeback port into the register file
	typedef struct packed {
		logic        enable;
		logic [4:0]  addr;
		logic [31:0] data;
	} regWrite_t;

	// ID/EX pipeline contents
	typedef struct packed {
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  destReg;
		logic [4:0]  shamt;
		logic [31:0] imm32;
		logic [3:0]  kind;
		logic [31:0] rsData;
		logic [31:0] rtData;
		logic [31:0] luiResult;
	} idExBundle_t;

	// Branch and jump outcome back to fetch
	typedef struct packed {
		logic        branchTaken;
		logic        jumpTaken;
		logic [31:0] branchTarget;
		logic [31:0] jumpTarget;
	} redirect_t;

endpackage

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input  decodePkg::instrWord_t  instr,
	output decodePkg::decodeCtrl_t ctrl
);

	logic [3:0] kind;

	////////////////////////////////////////
	// Opcode and funct to kind
	////////////////////////////////////////

	always_comb
	begin
		kind = decodePkg::kindIllegal;
		case (instr.r.opcode)
			decodePkg::opRType:
			begin
				// R-type kind comes from funct
				case (instr.r.funct)
					decodePkg::functAddu:
						kind = decodePkg::kindAddu;
					decodePkg::functSubu:
						kind = decodePkg::kindSubu;
					decodePkg::functJr:
						kind = decodePkg::kindJr;
					decodePkg::functSll:
					begin
						// All-zero word is the nop
						if (instr.r == '0)
							kind = decodePkg::kindNop;
						else
							kind = decodePkg::kindSll;
					end
					default:
						kind = decodePkg::kindIllegal;
				endcase
			end
			decodePkg::opOri:
				kind = decodePkg::kindOri;
			decodePkg::opLw:
				kind = decodePkg::kindLw;
			decodePkg::opSw:
				kind = decodePkg::kindSw;
			decodePkg::opBeq:
				kind = decodePkg::kindBeq;
			decodePkg::opLui:
				kind = decodePkg::kindLui;
			decodePkg::opJ:
				kind = decodePkg::kindJ;
			decodePkg::opJal:
				kind = decodePkg::kindJal;
			default:
				kind = decodePkg::kindIllegal;
		endcase
	end

	////////////////////////////////////////
	// Control flags from kind
	////////////////////////////////////////

	always_comb
	begin
		ctrl.kind = kind;
		// Logical immediates and shift amount are unsigned
		ctrl.zeroExtend = (kind == decodePkg::kindOri) ||
			(kind == decodePkg::kindSll);
		// I-type writers land in rt
		ctrl.writesRt = (kind == decodePkg::kindOri) ||
			(kind == decodePkg::kindLw) ||
			(kind == decodePkg::kindLui);
		// Only jal writes the link register
		ctrl.link = (kind == decodePkg::kindJal);
	end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [4:0]           rsAddr,
	input  logic [4:0]           rtAddr,
	input  decodePkg::regWrite_t wb,
	output logic [31:0]          rsData,
	output logic [31:0]          rtData
);

	// Register zero has no storage
	logic [31:0] regs [1:31];
	logic        writeActive;

	assign writeActive = wb.enable && (wb.addr != 5'd0);

	// Read with bypass of the same-cycle write
	function automatic logic [31:0] readPort(input logic [4:0] addr);
		logic [31:0] value;
		if (addr == 5'd0)
			value = 32'd0;
		else if (writeActive && (wb.addr == addr))
			value = wb.data;
		else
			value = regs[addr];
		return value;
	endfunction

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 1; n < 32; n++)
				regs[n] <= 32'd0;
		end
		else if (writeActive)
		begin
			regs[wb.addr] <= wb.data;
		end
	end

	// Two combinational read ports
	always_comb
	begin
		rsData = readPort(rsAddr);
		rtData = readPort(rtAddr);
	end

endmodule

//--- verilog/branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
	input  decodePkg::instrWord_t instr,
	input  logic [31:0]           pc,
	input  logic [3:0]            kind,
	input  logic [31:0]           imm32,
	input  logic [31:0]           rsData,
	input  logic [31:0]           rtData,
	output decodePkg::redirect_t  redirect
);

	logic isJump;
	logic isJr;

	assign isJr = (kind == decodePkg::kindJr);
	// Absolute jumps
	assign isJump = (kind == decodePkg::kindJ) || (kind == decodePkg::kindJal);

	////////////////////////////////////////
	// Branch
	////////////////////////////////////////

	always_comb
	begin
		// Only beq with equal operands
		redirect.branchTaken = (kind == decodePkg::kindBeq) && (rsData == rtData);
		// Word offset from the delay slot address
		redirect.branchTarget = pc + 32'd4 + {imm32[29:0], 2'b00};
	end

	////////////////////////////////////////
	// Jump
	////////////////////////////////////////

	always_comb
	begin
		redirect.jumpTaken = isJump || isJr;
		if (isJump)
			// Stay in current 256 MB region
			redirect.jumpTarget = {pc[31:28], instr.j.target26, 2'b00};
		else if (isJr)
			redirect.jumpTarget = rsData;
		else
			redirect.jumpTarget = decodePkg::resetVector;
	end

endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input  logic                   clk,
	input  logic                   reset,
	input  decodePkg::instrWord_t  instr,
	input  logic [31:0]            pc,
	output logic [4:0]             rsAddr,
	output logic [4:0]             rtAddr,
	input  logic [31:0]            rsData,
	input  logic [31:0]            rtData,
	output decodePkg::idExBundle_t idEx,
	output decodePkg::redirect_t   redirect
);

	decodePkg::decodeCtrl_t  ctrl;
	decodePkg::idExBundle_t  nextIdEx;
	logic                    isSll;
	logic [15:0]             immSrc;
	logic [31:0]             imm32;
	logic [31:0]             rsOperand;
	logic [4:0]              destReg;

	// Register numbers share position in every format
	assign rsAddr = instr.r.rs;
	assign rtAddr = instr.r.rt;

	instrDecoder u_instrDecoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	assign isSll = (ctrl.kind == decodePkg::kindSll);

	////////////////////////////////////////
	// Immediate and operands
	////////////////////////////////////////

	// sll feeds its shift amount through the immediate path
	assign immSrc = isSll ? {11'd0, instr.r.shamt} : instr.i.imm16;

	// Extender
	assign imm32 = ctrl.zeroExtend ? {16'd0, immSrc} : {{16{immSrc[15]}}, immSrc};

	// sll takes shamt in place of rs as sllv would
	assign rsOperand = isSll ? {27'd0, instr.r.shamt} : rsData;

	// Destination is link for jal, rt for I-type writers, else rd
	always_comb
	begin
		if (ctrl.link)
			destReg = decodePkg::linkReg;
		else if (ctrl.writesRt)
			destReg = instr.i.rt;
		else
			destReg = instr.r.rd;
	end

	branchUnit u_branchUnit (
		.instr    (instr),
		.pc       (pc),
		.kind     (ctrl.kind),
		.imm32    (imm32),
		.rsData   (rsOperand),
		.rtData   (rtData),
		.redirect (redirect)
	);

	// Next bundle
	always_comb
	begin
		nextIdEx.rs = instr.r.rs;
		nextIdEx.rt = instr.r.rt;
		nextIdEx.destReg = destReg;
		nextIdEx.shamt = instr.r.shamt;
		nextIdEx.imm32 = imm32;
		nextIdEx.kind = ctrl.kind;
		nextIdEx.rsData = rsOperand;
		nextIdEx.rtData = rtData;
		// lui result ready for the writeback
		nextIdEx.luiResult = {instr.i.imm16, 16'd0};
	end

	////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// Nop bundle
			idEx <= '0;
			idEx.kind <= decodePkg::kindNop;
		end
		else
		begin
			idEx <= nextIdEx;
		end
	end

endmodule

//--- verilog/decodeTop.sv
`timescale 1ns/1ps

module decodeTop (
	input  logic                   clk,
	input  logic                   reset,
	input  decodePkg::instrWord_t  instr,
	input  logic [31:0]            pc,
	input  decodePkg::regWrite_t   wb,
	output decodePkg::idExBundle_t idEx,
	output decodePkg::redirect_t   redirect
);

	// Read port wiring
	logic [4:0]  rsAddr;
	logic [4:0]  rtAddr;
	logic [31:0] rsData;
	logic [31:0] rtData;

	decodeStage u_decodeStage (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.pc       (pc),
		.rsAddr   (rsAddr),
		.rtAddr   (rtAddr),
		.rsData   (rsData),
		.rtData   (rtData),
		.idEx     (idEx),
		.redirect (redirect)
	);

	// Write port comes straight from writeback
	regFile u_regFile (
		.clk    (clk),
		.reset  (reset),
		.rsAddr (rsAddr),
		.rtAddr (rtAddr),
		.wb     (wb),
		.rsData (rsData),
		.rtData (rtData)
	);

endmodule

//--- tb/decodeChecks.svh
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

	// Keeps only the first differing field
	task automatic noteField(
		input string       name,
		input logic [31:0] got,
		input logic [31:0] exp,
		inout string       firstDiff
	);
		if ((firstDiff == "") && (got !== exp))
			firstDiff = $sformatf("MISMATCH %s got %h expected %h", name, got, exp);
	endtask

	// ID/EX bundle one cycle after the instruction
	task automatic checkIdEx(
		input decodePkg::idExBundle_t got,
		input decodePkg::idExBundle_t exp
	);
		string firstDiff;
		firstDiff = "";
		noteField("idEx.rs", got.rs, exp.rs, firstDiff);
		noteField("idEx.rt", got.rt, exp.rt, firstDiff);
		noteField("idEx.destReg", got.destReg, exp.destReg, firstDiff);
		noteField("idEx.shamt", got.shamt, exp.shamt, firstDiff);
		noteField("idEx.imm32", got.imm32, exp.imm32, firstDiff);
		noteField("idEx.kind", got.kind, exp.kind, firstDiff);
		noteField("idEx.rsData", got.rsData, exp.rsData, firstDiff);
		noteField("idEx.rtData", got.rtData, exp.rtData, firstDiff);
		noteField("idEx.luiResult", got.luiResult, exp.luiResult, firstDiff);
		if (firstDiff != "")
			failRun(firstDiff);
	endtask

	// Redirect in the same cycle as the instruction
	task automatic checkRedirect(
		input decodePkg::redirect_t got,
		input decodePkg::redirect_t exp
	);
		string firstDiff;
		firstDiff = "";
		noteField("redirect.branchTaken", got.branchTaken, exp.branchTaken, firstDiff);
		noteField("redirect.jumpTaken", got.jumpTaken, exp.jumpTaken, firstDiff);
		noteField("redirect.branchTarget", got.branchTarget, exp.branchTarget, firstDiff);
		noteField("redirect.jumpTarget", got.jumpTarget, exp.jumpTarget, firstDiff);
		if (firstDiff != "")
			failRun(firstDiff);
	endtask

`endif

//--- tb/decodeTb.sv
`timescale 1ns/1ps

module decodeTb;

	// One line of the stimulus file
	typedef struct packed {
		logic                   isWrite;
		decodePkg::regWrite_t   wb;
		decodePkg::instrWord_t  instr;
		logic [31:0]            pc;
		decodePkg::idExBundle_t expIdEx;
		decodePkg::redirect_t   expRedirect;
	} record_t;

	logic                   clk;
	logic                   reset;
	decodePkg::instrWord_t  instr;
	logic [31:0]            pc;
	decodePkg::regWrite_t   wb;
	decodePkg::idExBundle_t idEx;
	decodePkg::redirect_t   redirect;

	record_t                records [$];
	logic                   loaded;
	decodePkg::idExBundle_t nopBundle;
	// Bundle due after the next edge
	decodePkg::idExBundle_t prevIdEx;
	logic                   havePrev;

	decodeTop u_decodeTop (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.pc       (pc),
		.wb       (wb),
		.idEx     (idEx),
		.redirect (redirect)
	);

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	`include "decodeChecks.svh"

	////////////////////////////////////////
	// Clock and watchdog
	////////////////////////////////////////

	// 20 ns period
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Four periods per record plus 1 us
	initial
	begin
		wait (loaded === 1'b1);
		#(records.size() * 80 + 1000);
		failRun("Watchdog expired, the run timed out");
	end

	////////////////////////////////////////
	// Stimulus file
	////////////////////////////////////////

	task automatic loadStimulus();
		int          fd;
		int          code;
		string       tag;
		string       rest;
		logic [31:0] f [0:14];
		logic        formatError;
		record_t     rec;
		formatError = 1'b0;
		fd = $fopen("tb/decodeStimulus.txt", "r");
		if (fd == 0)
			failRun("Cannot open the stimulus file tb/decodeStimulus.txt");
		else
		begin
			while (!$feof(fd))
			begin
				code = $fscanf(fd, "%s", tag);
				rec = '0;
				if ((code == 1) && (tag == "#"))
					code = $fgets(rest, fd);
				else if ((code == 1) && (tag == "W"))
				begin
					// enable, addr, data
					if ($fscanf(fd, "%h %h %h", f[0], f[1], f[2]) != 3)
						formatError = 1'b1;
					rec.isWrite = 1'b1;
					rec.wb = {f[0][0], f[1][4:0], f[2]};
					records.push_back(rec);
				end
				else if ((code == 1) && (tag == "I"))
				begin
					code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
						f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
					if (code != 15)
						formatError = 1'b1;
					rec.instr = f[0];
					rec.pc = f[1];
					rec.expIdEx = {f[2][4:0], f[3][4:0], f[4][4:0], f[5][4:0], f[6],
						f[7][3:0], f[8], f[9], f[10]};
					rec.expRedirect = {f[11][0], f[12][0], f[13], f[14]};
					records.push_back(rec);
				end
				else if (code == 1)
					formatError = 1'b1;
			end
			$fclose(fd);
			if (formatError || (records.size() == 0))
				failRun("The stimulus file is malformed or holds no records");
		end
	endtask

	// Drive on the rising edge and check at the falling edge
	task automatic driveCycle(
		input decodePkg::regWrite_t   w,
		input decodePkg::instrWord_t  i,
		input logic [31:0]            p,
		input logic                   checkRedir,
		input decodePkg::redirect_t   expRedir,
		input decodePkg::idExBundle_t expNext
	);
		@(posedge clk);
		wb <= w;
		instr <= i;
		pc <= p;
		@(negedge clk);
		if (havePrev)
			checkIdEx(idEx, prevIdEx);
		if (checkRedir)
			checkRedirect(redirect, expRedir);
		prevIdEx = expNext;
		havePrev = 1'b1;
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		decodePkg::regWrite_t pendingWb;
		logic                 havePending;
		reset = 1'b1;
		// Illegal word held through reset exposes a missed clear
		instr = 32'hffff_ffff;
		pc = '0;
		wb = '0;
		loaded = 1'b0;
		havePrev = 1'b0;
		havePending = 1'b0;
		pendingWb = '0;
		nopBundle = '0;
		nopBundle.kind = decodePkg::kindNop;
		prevIdEx = nopBundle;
		loadStimulus();
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		instr <= '0;
		// Bundle left by reset
		@(negedge clk);
		checkIdEx(idEx, nopBundle);
		// Edge after reset release captures the zero word
		havePrev = 1'b1;
		foreach (records[n])
		begin
			if (records[n].isWrite)
			begin
				// Older of two back to back writes gets a cycle of its own
				if (havePending)
					driveCycle(pendingWb, '0, 32'd0, 1'b0, '0, nopBundle);
				pendingWb = records[n].wb;
				havePending = 1'b1;
			end
			else
			begin
				// A waiting write shares the cycle with this instruction
				driveCycle(pendingWb, records[n].instr, records[n].pc, 1'b1,
					records[n].expRedirect, records[n].expIdEx);
				pendingWb = '0;
				havePending = 1'b0;
			end
		end
		if (havePending)
			driveCycle(pendingWb, '0, 32'd0, 1'b0, '0, nopBundle);
		// Flush the last bundle
		driveCycle('0, '0, 32'd0, 1'b0, '0, nopBundle);
		$display("All checks passed");
		$finish;
	end

endmodule

//--- tb/decodeStimulus.txt
# W enable addr data
# I instr pc rs rt destReg shamt imm32 kind rsData rtData luiResult brTaken jTaken brTarget jTarget
# Out of reset, all-zero word
I 00000000 00000000 00 00 00 00 00000000 0 00000000 00000000 00000000 0 0 00000004 00003000
# Register setup, write to r0 is dropped
W 1 01 12345678
W 1 02 00000005
W 1 03 12345678
W 1 00 deadbeef
W 1 04 00400080
# addu, subu reading r0
I 00222821 00400000 01 02 05 00 00002821 1 12345678 00000005 28210000 0 0 0040a088 00003000
I 00403023 00400004 02 00 06 00 00003023 2 00000005 00000000 30230000 0 0 0040c094 00003000
# Immediates and destinations
I 34278001 00400008 01 07 07 00 00008001 3 12345678 00000000 80010000 0 0 00420010 00003000
I 8c28fff8 0040000c 01 08 08 1f fffffff8 4 12345678 00000000 fff80000 0 0 003ffff0 00003000
I ac620010 00400010 03 02 00 00 00000010 5 12345678 00000005 00100000 0 0 00400054 00003000
I 3c09abcd 00400014 00 09 09 0f ffffabcd 7 00000000 00000000 abcd0000 0 0 003eaf4c 00003000
I 000250c0 00400018 00 02 0a 03 00000003 b 00000003 00000005 50c00000 0 0 00400028 00003000
# Branches and jumps
I 10230004 0040001c 01 03 00 00 00000004 6 12345678 12345678 00040000 1 0 00400030 00003000
I 1022fffe 00400020 01 02 1f 1f fffffffe 6 12345678 00000005 fffe0000 0 0 0040001c 00003000
I 08100040 a0000024 00 10 00 01 00000040 8 00000000 00000000 00400000 0 1 a0000128 a0400100
I 0c200008 30000028 01 00 1f 00 00000008 9 12345678 00000000 00080000 0 1 3000004c 30800020
I 00800008 0040002c 04 00 00 00 00000008 a 00400080 00000000 00080000 0 1 00400050 00400080
# Same-cycle write reaches rsData and beq
W 1 0b cafef00d
I 01616021 00400030 0b 01 0c 00 00006021 1 cafef00d 12345678 60210000 0 0 004180b8 00003000
W 1 0c 12345678
I 11810008 00400034 0c 01 00 00 00000008 6 12345678 12345678 00080000 1 0 00400058 00003000
# Both writes held
I 016c6823 00400038 0b 0c 0d 00 00006823 2 cafef00d 12345678 68230000 0 0 0041a0c8 00003000
I 00000000 00400040 00 00 00 00 00000000 0 00000000 00000000 00000000 0 0 00400044 00003000

//--- compile.f
+incdir+tb
verilog/decodePkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/branchUnit.sv
verilog/decodeStage.sv
verilog/decodeTop.sv
tb/decodeTb.sv

//--- Bender.yml
package:
  name: mips_decode

sources:
  - files:
      - verilog/decodePkg.sv
      - verilog/instrDecoder.sv
      - verilog/regFile.sv
      - verilog/branchUnit.sv
      - verilog/decodeStage.sv
      - verilog/decodeTop.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/decodeTb.sv
